// ==== logic/uart_cmd_pkg.sv ====
package uart_cmd_pkg;

	////////////////////////////////////////////////////////////
	// Serial timing
	////////////////////////////////////////////////////////////

	// Clocks per serial bit, shared by receiver and transmitter
	localparam int BAUD_DIV = 16;
	// Wide enough to hold BAUD_DIV - 1
	localparam int BAUD_CNT_W = 5;

	////////////////////////////////////////////////////////////
	// Byte buffer
	////////////////////////////////////////////////////////////

	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_PTR_W = 3;

	////////////////////////////////////////////////////////////
	// Command set
	////////////////////////////////////////////////////////////

	// Host opcodes, any other byte is ignored
	typedef enum logic [7:0] {
		OP_SET    = 8'h01,
		OP_TOGGLE = 8'h02,
		OP_REPORT = 8'h04,
		OP_CLEAR  = 8'h05
	} cmd_op_e;

	// Executor states
	typedef enum logic [1:0] {
		EX_OPCODE,
		EX_ARG_SET,
		EX_ARG_TOGGLE
	} exec_state_e;

	// Received byte with its one-cycle strobe
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} rx_byte_t;

endpackage

// ==== logic/uart_rx.sv ====
module uart_rx (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  rxd,
	output uart_cmd_pkg::rx_byte_t rx_byte
);
	import uart_cmd_pkg::*;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	rx_state_e               state;
	logic [BAUD_CNT_W-1:0]   baud_cnt;
	logic [2:0]              bit_idx;
	logic                    rx_meta;
	logic                    rx_sync;
	logic                    rx_prev;
	logic                    valid_q;
	logic [7:0]              shift_q;
	logic                    bit_tick;
	logic                    half_tick;

	// Two-flop synchronizer plus one stage for edge detect
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rxd;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign bit_tick  = (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1));
	assign half_tick = (baud_cnt == BAUD_CNT_W'(BAUD_DIV / 2 - 1));

	////////////////////////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= RX_IDLE;
			baud_cnt <= '0;
			bit_idx  <= '0;
			valid_q  <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			case (state)
				RX_IDLE: begin
					baud_cnt <= '0;
					// Falling edge only, so a stuck-low line never restarts
					if (rx_prev && !rx_sync)
						state <= RX_START;
				end
				RX_START: begin
					if (half_tick) begin
						baud_cnt <= '0;
						bit_idx  <= '0;
						// Glitch rejection at mid start bit
						state    <= rx_sync ? RX_IDLE : RX_DATA;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (bit_tick) begin
						baud_cnt <= '0;
						bit_idx  <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				RX_STOP: begin
					if (bit_tick) begin
						baud_cnt <= '0;
						valid_q  <= rx_sync;
						state    <= RX_IDLE;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge clk) begin
		if (state == RX_DATA && bit_tick)
			shift_q <= {rx_sync, shift_q[7:1]};
	end

	assign rx_byte = '{valid: valid_q, data: shift_q};

endmodule

// ==== logic/byte_fifo.sv ====
module byte_fifo (
	input  logic                   clk,
	input  logic                   rst_n,
	input  uart_cmd_pkg::rx_byte_t rx_byte,
	input  logic                   fifo_pop,
	output logic [7:0]             fifo_data,
	output logic                   fifo_empty
);
	import uart_cmd_pkg::*;

	logic [7:0]            mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_PTR_W:0]   count;
	logic                  full;
	logic                  do_push;
	logic                  do_pop;

	assign full       = (count == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
	assign fifo_empty = (count == '0);

	// Overflow bytes are silently dropped
	assign do_push = rx_byte.valid && !full;
	assign do_pop  = fifo_pop && !fifo_empty;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= rx_byte.data;
	end

	////////////////////////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////////////////////////

	// Depth is a power of two, pointers wrap on their own
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// Show-ahead, oldest entry always on the output
	assign fifo_data = mem[rd_ptr];

endmodule

// ==== logic/led_cmd_exec.sv ====
module led_cmd_exec (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [7:0] fifo_data,
	input  logic       fifo_empty,
	input  logic       tx_busy,
	output logic       fifo_pop,
	output logic       tx_start,
	output logic [7:0] tx_data,
	output logic [7:0] leds
);
	import uart_cmd_pkg::*;

	exec_state_e state;
	cmd_op_e     op;

	assign op = cmd_op_e'(fifo_data);

	// Hold bytes in the FIFO while a reply is on the wire
	assign fifo_pop = !fifo_empty && !tx_busy;

	// Reply starts in the same cycle the REPORT byte is popped
	assign tx_start = fifo_pop && (state == EX_OPCODE) && (op == OP_REPORT);
	assign tx_data  = leds;

	////////////////////////////////////////////////////////////
	// Opcode interpreter
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= EX_OPCODE;
			leds  <= '0;
		end else if (fifo_pop) begin
			case (state)
				EX_OPCODE: begin
					case (op)
						OP_CLEAR:  leds  <= '0;
						OP_SET:    state <= EX_ARG_SET;
						OP_TOGGLE: state <= EX_ARG_TOGGLE;
						// REPORT handled by tx_start, stray bytes dropped
						default: ;
					endcase
				end
				// Argument may be any value, opcodes included
				EX_ARG_SET: begin
					leds  <= fifo_data;
					state <= EX_OPCODE;
				end
				EX_ARG_TOGGLE: begin
					leds  <= leds ^ fifo_data;
					state <= EX_OPCODE;
				end
				default: state <= EX_OPCODE;
			endcase
		end
	end

endmodule

// ==== logic/uart_tx.sv ====
module uart_tx (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       tx_start,
	input  logic [7:0] tx_data,
	output logic       txd,
	output logic       tx_busy
);
	import uart_cmd_pkg::*;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

	tx_state_e             state;
	logic [BAUD_CNT_W-1:0] baud_cnt;
	logic [2:0]            bit_idx;
	logic [7:0]            shift_q;
	logic                  bit_tick;

	assign bit_tick = (baud_cnt == BAUD_CNT_W'(BAUD_DIV - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= TX_IDLE;
			baud_cnt <= '0;
			bit_idx  <= '0;
			txd      <= 1'b1;
			tx_busy  <= 1'b0;
		end else begin
			baud_cnt <= bit_tick ? '0 : baud_cnt + 1'b1;
			case (state)
				TX_IDLE: begin
					baud_cnt <= '0;
					if (tx_start) begin
						txd     <= 1'b0;
						tx_busy <= 1'b1;
						state   <= TX_START;
					end
				end
				TX_START: begin
					if (bit_tick) begin
						txd     <= shift_q[0];
						bit_idx <= '0;
						state   <= TX_DATA;
					end
				end
				TX_DATA: begin
					if (bit_tick) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							txd   <= 1'b1;
							state <= TX_STOP;
						end else begin
							txd <= shift_q[0];
						end
					end
				end
				TX_STOP: begin
					// Busy covers the whole stop bit
					if (bit_tick) begin
						tx_busy <= 1'b0;
						state   <= TX_IDLE;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// Next data bit always sits in bit 0
	always_ff @(posedge clk) begin
		if (state == TX_IDLE && tx_start)
			shift_q <= tx_data;
		else if (bit_tick && (state == TX_START || state == TX_DATA))
			shift_q <= {1'b0, shift_q[7:1]};
	end

endmodule

// ==== logic/uart_led_top.sv ====
module uart_led_top (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       rxd,
	output logic       txd,
	output logic [7:0] leds
);
	import uart_cmd_pkg::*;

	rx_byte_t   rx_byte;
	logic [7:0] fifo_data;
	logic       fifo_empty;
	logic       fifo_pop;
	logic       tx_start;
	logic [7:0] tx_data;
	logic       tx_busy;

	////////////////////////////////////////////////////////////
	// Receive path
	////////////////////////////////////////////////////////////

	uart_rx u_rx (
		.clk     (clk),
		.rst_n   (rst_n),
		.rxd     (rxd),
		.rx_byte (rx_byte)
	);

	byte_fifo u_fifo (
		.clk        (clk),
		.rst_n      (rst_n),
		.rx_byte    (rx_byte),
		.fifo_pop   (fifo_pop),
		.fifo_data  (fifo_data),
		.fifo_empty (fifo_empty)
	);

	////////////////////////////////////////////////////////////
	// Command execution and replies
	////////////////////////////////////////////////////////////

	led_cmd_exec u_exec (
		.clk        (clk),
		.rst_n      (rst_n),
		.fifo_data  (fifo_data),
		.fifo_empty (fifo_empty),
		.tx_busy    (tx_busy),
		.fifo_pop   (fifo_pop),
		.tx_start   (tx_start),
		.tx_data    (tx_data),
		.leds       (leds)
	);

	uart_tx u_tx (
		.clk      (clk),
		.rst_n    (rst_n),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.txd      (txd),
		.tx_busy  (tx_busy)
	);

endmodule

// ==== verif/tb_uart_led.sv ====
module tb_uart_led;
	timeunit 1ns;
	timeprecision 1ps;

	import uart_cmd_pkg::*;

	typedef struct packed {
		logic [7:0] data;
		logic       bad_stop;
		logic       burst;
		logic [7:0] exp_leds;
		logic       exp_reply;
		logic [7:0] exp_reply_data;
	} stim_t;

	logic       clk = 1'b0;
	logic       rst_n;
	logic       rxd;
	logic       txd;
	logic [7:0] leds;

	stim_t       table_q[$];
	logic [7:0]  frame_q[$];
	logic [7:0]  exp_q[$];
	exec_state_e model_state;
	logic [7:0]  model_leds;
	logic [31:0] lcg_state = 32'h8798022a;
	logic [31:0] rnd;

	// Reply monitor state
	logic        mon_active;
	int          mon_cnt;
	int          mon_bit;
	logic [7:0]  mon_shift;

	uart_led_top UUT (
		.clk   (clk),
		.rst_n (rst_n),
		.rxd   (rxd),
		.txd   (txd),
		.leds  (leds)
	);

	always #10 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task automatic compare_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (exp !== act) begin
			$display("FAILED: %s expected 0x%0h actual 0x%0h", name, exp, act);
			$display("TESTBENCH FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timeout while waiting: %s", what);
		$display("TESTBENCH FAILED");
		$fatal(1, "timeout");
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Reference command model used while the table is built
	task automatic add_entry(input logic [7:0] data, input logic bad_stop,
			input logic burst);
		stim_t e;
		e.data           = data;
		e.bad_stop       = bad_stop;
		e.burst          = burst;
		e.exp_reply      = 1'b0;
		e.exp_reply_data = '0;
		if (!bad_stop) begin
			case (model_state)
				EX_OPCODE: begin
					if (data == OP_CLEAR) begin
						model_leds = '0;
					end else if (data == OP_REPORT) begin
						e.exp_reply      = 1'b1;
						e.exp_reply_data = model_leds;
					end else if (data == OP_SET) begin
						model_state = EX_ARG_SET;
					end else if (data == OP_TOGGLE) begin
						model_state = EX_ARG_TOGGLE;
					end
				end
				EX_ARG_SET: begin
					model_leds  = data;
					model_state = EX_OPCODE;
				end
				EX_ARG_TOGGLE: begin
					model_leds  = model_leds ^ data;
					model_state = EX_OPCODE;
				end
				default: model_state = EX_OPCODE;
			endcase
		end
		e.exp_leds = model_leds;
		table_q.push_back(e);
	endtask

	// 8N1 frame with the stop bit forced low on request
	task automatic send_byte(input logic [7:0] data, input logic bad_stop);
		logic [9:0] frame;
		frame = {~bad_stop, data, 1'b0};
		for (int b = 0; b < 10; b++) begin
			@(posedge clk);
			rxd <= frame[b];
			repeat (BAUD_DIV - 1) @(posedge clk);
		end
		// Line back high after a low stop bit
		if (bad_stop) begin
			@(posedge clk);
			rxd <= 1'b1;
		end
	endtask

	task automatic collect_replies();
		int         waited;
		logic [7:0] got;
		waited = 0;
		while (frame_q.size() < exp_q.size()) begin
			@(posedge clk);
			waited++;
			if (waited > 24 * BAUD_DIV)
				abort_on_timeout("reply frame on txd");
		end
		while (exp_q.size() > 0) begin
			got = frame_q.pop_front();
			compare_value("txd reply", 32'(exp_q.pop_front()), 32'(got));
		end
		compare_value("extra reply frames", 32'd0, 32'(frame_q.size()));
	endtask

	////////////////////////////////////////////////////////////
	// Serial monitor on txd sampling at mid-bit
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (!rst_n) begin
			mon_active = 1'b0;
			mon_cnt    = 0;
		end else if (!mon_active) begin
			if (!txd) begin
				mon_active = 1'b1;
				mon_cnt    = 0;
			end
		end else begin
			mon_cnt++;
			if (mon_cnt % BAUD_DIV == BAUD_DIV / 2) begin
				mon_bit = mon_cnt / BAUD_DIV;
				if (mon_bit == 0) begin
					compare_value("txd start bit", 32'd0, 32'(txd));
				end else if (mon_bit < 9) begin
					mon_shift[mon_bit - 1] = txd;
				end else begin
					compare_value("txd stop bit", 32'd1, 32'(txd));
					frame_q.push_back(mon_shift);
					mon_active = 1'b0;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial begin
		rst_n       = 1'b0;
		rxd         = 1'b1;
		model_state = EX_OPCODE;
		model_leds  = '0;

		// Reference stream with stray bytes after the SET argument
		add_entry(8'h01, 1'b0, 1'b0);
		add_entry(8'h60, 1'b0, 1'b0);
		add_entry(8'h61, 1'b0, 1'b0);
		add_entry(8'h62, 1'b0, 1'b0);
		add_entry(8'h00, 1'b0, 1'b0);
		add_entry(OP_REPORT, 1'b0, 1'b0);
		// Random arguments
		rnd = lcg_next();
		add_entry(OP_TOGGLE, 1'b0, 1'b0);
		add_entry(rnd[23:16], 1'b0, 1'b0);
		add_entry(OP_REPORT, 1'b0, 1'b0);
		rnd = lcg_next();
		add_entry(OP_SET, 1'b0, 1'b0);
		add_entry(rnd[23:16], 1'b0, 1'b0);
		add_entry(OP_REPORT, 1'b0, 1'b0);
		rnd = lcg_next();
		add_entry(OP_TOGGLE, 1'b0, 1'b0);
		add_entry(rnd[23:16], 1'b0, 1'b0);
		add_entry(OP_CLEAR, 1'b0, 1'b0);
		add_entry(OP_REPORT, 1'b0, 1'b0);
		// Bad stop bit is dropped
		add_entry(OP_SET, 1'b0, 1'b0);
		add_entry(8'hA5, 1'b0, 1'b0);
		add_entry(OP_CLEAR, 1'b1, 1'b0);
		add_entry(OP_REPORT, 1'b0, 1'b0);
		add_entry(OP_TOGGLE, 1'b0, 1'b0);
		add_entry(8'h0F, 1'b0, 1'b0);
		// Back to back reports under back-pressure
		add_entry(OP_REPORT, 1'b0, 1'b1);
		add_entry(OP_REPORT, 1'b0, 1'b1);
		add_entry(OP_REPORT, 1'b0, 1'b0);

		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		// Idle line after reset
		compare_value("leds", 32'd0, 32'(leds));
		repeat (4 * BAUD_DIV) begin
			@(posedge clk);
			compare_value("txd", 32'd1, 32'(txd));
		end

		foreach (table_q[i]) begin
			send_byte(table_q[i].data, table_q[i].bad_stop);
			if (table_q[i].exp_reply)
				exp_q.push_back(table_q[i].exp_reply_data);
			if (!table_q[i].burst) begin
				repeat (2 * BAUD_DIV) @(posedge clk);
				compare_value("leds", 32'(table_q[i].exp_leds), 32'(leds));
				collect_replies();
			end
		end

		// Nothing further may appear on txd
		repeat (12 * BAUD_DIV) @(posedge clk);
		collect_replies();

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== compile.f ====
logic/uart_cmd_pkg.sv
logic/uart_rx.sv
logic/byte_fifo.sv
logic/led_cmd_exec.sv
logic/uart_tx.sv
logic/uart_led_top.sv
verif/tb_uart_led.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the UART LED testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_uart_led -o sim_uart_led
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_uart_led)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TESTBENCH PASSED"; then
	exit 0
fi
exit 1
